//--- source/dcache_pkg.sv
package dcache_pkg;

    // processor address and data widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned WORD_W = 32;
    // byte offset inside a word
    localparam int unsigned BYTE_OFF_W = 2;

    // width of one way's age counter
    localparam int unsigned AGE_W = 8;

    typedef logic [WORD_W-1:0] word_t;

    // lane 0 is bits 7..0
    typedef logic [WORD_W/8-1:0] sel_t;

    // wishbone master to slave, used on both cpu and memory sides
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        word_t adr;
        word_t dat;
    } wb_m2s_t;

    // wishbone slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    // controller states
    typedef enum logic [1:0] {
        LOOKUP,
        EVICT,
        REFILL,
        RESPOND
    } ctrl_state_e;

endpackage

//--- source/lru_tracker.sv
`timescale 1ns/10ps

module lru_tracker #(
    parameter int unsigned SET_ADDR_LEN = 2,
    parameter int unsigned WAY_CNT      = 4,
    localparam int unsigned WAY_W = $clog2(WAY_CNT)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [SET_ADDR_LEN-1:0] set_i,
    input  logic                    touch_i,
    input  logic [WAY_W-1:0]        touch_way_i,
    output logic [WAY_W-1:0]        victim_way_o
);

    localparam int unsigned SETS = 1 << SET_ADDR_LEN;
    localparam logic [dcache_pkg::AGE_W-1:0] AGE_MAX = '1;

    logic [dcache_pkg::AGE_W-1:0] ages_q [SETS][WAY_CNT];
    logic [dcache_pkg::AGE_W-1:0] best_age;

    // touched way becomes youngest, the others age and saturate
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAY_CNT; w++)
                begin
                    ages_q[s][w] <= AGE_MAX;
                end
            end
        end
        else if (touch_i)
        begin
            for (int w = 0; w < WAY_CNT; w++)
            begin
                if (WAY_W'(w) == touch_way_i)
                begin
                    ages_q[set_i][w] <= '0;
                end
                else if (ages_q[set_i][w] != AGE_MAX)
                begin
                    ages_q[set_i][w] <= ages_q[set_i][w] + 1'b1;
                end
            end
        end
    end

    // oldest way wins, strict compare keeps the lowest index on ties
    always_comb
    begin
        best_age     = ages_q[set_i][0];
        victim_way_o = '0;
        for (int w = 1; w < WAY_CNT; w++)
        begin
            if (ages_q[set_i][w] > best_age)
            begin
                best_age     = ages_q[set_i][w];
                victim_way_o = WAY_W'(w);
            end
        end
    end

    // touched way is youngest and no longer the victim of its set
    touch_resets_age_a: assert property (@(posedge clk) disable iff (rst)
        touch_i |=> ages_q[$past(set_i)][$past(touch_way_i)] == {dcache_pkg::AGE_W{1'b0}}
            && (set_i != $past(set_i) || victim_way_o != $past(touch_way_i)));

endmodule

//--- source/dcache_store.sv
`timescale 1ns/10ps

module dcache_store #(
    parameter int unsigned LINE_ADDR_LEN = 2,
    parameter int unsigned SET_ADDR_LEN  = 2,
    parameter int unsigned WAY_CNT       = 4,
    localparam int unsigned TAG_W = dcache_pkg::ADDR_W - SET_ADDR_LEN - LINE_ADDR_LEN
        - dcache_pkg::BYTE_OFF_W,
    localparam int unsigned WAY_W = $clog2(WAY_CNT)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [SET_ADDR_LEN-1:0]  set_i,
    input  logic [TAG_W-1:0]         tag_i,
    input  logic [LINE_ADDR_LEN-1:0] word_i,
    input  logic                     lookup_i,
    input  logic                     wr_en_i,
    input  dcache_pkg::sel_t         wr_sel_i,
    input  dcache_pkg::word_t        wr_data_i,
    input  logic                     fill_en_i,
    input  logic [WAY_W-1:0]         fill_way_i,
    input  logic [LINE_ADDR_LEN-1:0] fill_word_i,
    input  dcache_pkg::word_t        fill_data_i,
    input  logic [WAY_W-1:0]         evict_way_i,
    input  logic [LINE_ADDR_LEN-1:0] evict_word_i,
    output logic                     hit_o,
    output logic [WAY_W-1:0]         hit_way_o,
    output dcache_pkg::word_t        rd_word_o,
    output logic                     victim_dirty_o,
    output dcache_pkg::word_t        evict_data_o,
    output logic [TAG_W-1:0]         evict_tag_o
);

    localparam int unsigned SETS = 1 << SET_ADDR_LEN;
    localparam int unsigned LINE_SIZE = 1 << LINE_ADDR_LEN;
    localparam logic [LINE_ADDR_LEN-1:0] LAST_WORD = '1;

    dcache_pkg::word_t data_q [SETS][WAY_CNT][LINE_SIZE];
    logic [TAG_W-1:0]  tag_q   [SETS][WAY_CNT];
    logic              valid_q [SETS][WAY_CNT];
    logic              dirty_q [SETS][WAY_CNT];

    logic             match_any;
    logic [WAY_W-1:0] match_way;
    logic             fill_last;

    // compare all ways of the set at once
    always_comb
    begin
        match_any = 1'b0;
        match_way = '0;
        for (int w = 0; w < WAY_CNT; w++)
        begin
            if (valid_q[set_i][w] && tag_q[set_i][w] == tag_i)
            begin
                match_any = 1'b1;
                match_way = WAY_W'(w);
            end
        end
    end

    // last fill word completes the line
    assign fill_last = fill_en_i && (fill_word_i == LAST_WORD);

    // lookup result registered, one cycle after the index
    always_ff @(posedge clk)
    begin
        if (lookup_i)
        begin
            hit_way_o <= match_way;
            rd_word_o <= data_q[set_i][match_way][word_i];
        end
    end

    // line state bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_o <= 1'b0;
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAY_CNT; w++)
                begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end
        else
        begin
            if (lookup_i)
            begin
                hit_o <= match_any;
            end
            if (wr_en_i)
            begin
                dirty_q[set_i][hit_way_o] <= 1'b1;
            end
            if (fill_last)
            begin
                valid_q[set_i][fill_way_i] <= 1'b1;
                dirty_q[set_i][fill_way_i] <= 1'b0;
            end
        end
    end

    // data and tag arrays
    always_ff @(posedge clk)
    begin
        // byte-lane merge into the hit way
        if (wr_en_i)
        begin
            for (int b = 0; b < $bits(dcache_pkg::sel_t); b++)
            begin
                if (wr_sel_i[b])
                begin
                    data_q[set_i][hit_way_o][word_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
        if (fill_en_i)
        begin
            data_q[set_i][fill_way_i][fill_word_i] <= fill_data_i;
        end
        if (fill_last)
        begin
            tag_q[set_i][fill_way_i] <= tag_i;
        end
    end

    // victim side seen by the controller and the mover
    assign victim_dirty_o = valid_q[set_i][evict_way_i] & dirty_q[set_i][evict_way_i];
    assign evict_data_o   = data_q[set_i][evict_way_i][evict_word_i];
    assign evict_tag_o    = tag_q[set_i][evict_way_i];

endmodule

//--- source/line_mover.sv
`timescale 1ns/10ps

module line_mover #(
    parameter int unsigned LINE_ADDR_LEN = 2,
    localparam int unsigned LADR_W = dcache_pkg::ADDR_W - LINE_ADDR_LEN
        - dcache_pkg::BYTE_OFF_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic                     write_i,
    input  logic [LADR_W-1:0]        line_adr_i,
    input  dcache_pkg::word_t        wr_word_i,
    output dcache_pkg::wb_m2s_t      mem_req_o,
    input  dcache_pkg::wb_s2m_t      mem_rsp_i,
    output logic [LINE_ADDR_LEN-1:0] word_idx_o,
    output logic                     fill_en_o,
    output dcache_pkg::word_t        fill_data_o,
    output logic                     done_o
);

    localparam logic [LINE_ADDR_LEN-1:0] LAST_WORD = '1;

    logic              busy_q;
    logic              we_q;
    logic [LADR_W-1:0] line_q;
    logic              beat_done;

    assign beat_done = busy_q & mem_rsp_i.ack;

    // burst sequencing, one word per bus cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q     <= 1'b0;
            done_o     <= 1'b0;
            word_idx_o <= '0;
        end
        else
        begin
            done_o <= 1'b0;
            if (start_i)
            begin
                busy_q     <= 1'b1;
                word_idx_o <= '0;
            end
            else if (beat_done)
            begin
                word_idx_o <= word_idx_o + 1'b1;
                // last ack ends the burst
                if (word_idx_o == LAST_WORD)
                begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // direction and line held for the whole burst
    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            we_q   <= write_i;
            line_q <= line_adr_i;
        end
    end

    // request fields only move after an ack
    assign mem_req_o.cyc = busy_q;
    assign mem_req_o.stb = busy_q;
    assign mem_req_o.we  = we_q;
    assign mem_req_o.sel = '1;
    assign mem_req_o.adr = {line_q, word_idx_o, {dcache_pkg::BYTE_OFF_W{1'b0}}};
    assign mem_req_o.dat = wr_word_i;

    // refill words go straight into the store
    assign fill_en_o   = beat_done & ~we_q;
    assign fill_data_o = mem_rsp_i.dat;

    req_stable_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req_o.stb && !mem_rsp_i.ack) |=> $stable(mem_req_o));

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int unsigned WAY_CNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  dcache_pkg::wb_m2s_t        cpu_req_i,
    output dcache_pkg::wb_s2m_t        cpu_rsp_o,
    output logic                       lookup_o,
    input  logic                       hit_i,
    input  logic                       victim_dirty_i,
    input  dcache_pkg::word_t          rd_word_i,
    output logic                       wr_en_o,
    output logic                       touch_o,
    input  logic [$clog2(WAY_CNT)-1:0] hit_way_i,
    input  logic [$clog2(WAY_CNT)-1:0] victim_way_i,
    output logic                       move_start_o,
    output logic                       move_write_o,
    input  logic                       move_done_i
);

    dcache_pkg::ctrl_state_e state_q;
    // lookup result from the store is valid this cycle
    logic look_vld_q;
    // one cycle start pulse for the line mover
    logic start_q;
    logic req;
    logic hit_now;

    assign req = cpu_req_i.cyc & cpu_req_i.stb;

    // present the address once per request, then wait for the registered result
    assign lookup_o = (state_q == dcache_pkg::LOOKUP) & req & ~look_vld_q;
    assign hit_now  = (state_q == dcache_pkg::LOOKUP) & look_vld_q & hit_i;

    // store merges the write into the hit way
    assign wr_en_o = hit_now & cpu_req_i.we;
    assign touch_o = hit_now;

    // single ack in RESPOND, data is the word latched at lookup
    assign cpu_rsp_o.ack = (state_q == dcache_pkg::RESPOND);
    assign cpu_rsp_o.dat = rd_word_i;

    assign move_start_o = start_q;
    // mover samples this together with start
    assign move_write_o = (state_q == dcache_pkg::EVICT);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= dcache_pkg::LOOKUP;
            look_vld_q <= 1'b0;
            start_q    <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            case (state_q)
                dcache_pkg::LOOKUP:
                begin
                    if (look_vld_q)
                    begin
                        look_vld_q <= 1'b0;
                        if (hit_i)
                        begin
                            state_q <= dcache_pkg::RESPOND;
                        end
                        else
                        begin
                            // miss, dirty victim goes out first
                            state_q <= victim_dirty_i ? dcache_pkg::EVICT : dcache_pkg::REFILL;
                            start_q <= 1'b1;
                        end
                    end
                    else
                    begin
                        look_vld_q <= req;
                    end
                end
                dcache_pkg::EVICT:
                begin
                    // write-back finished, fetch the new line
                    if (move_done_i)
                    begin
                        state_q <= dcache_pkg::REFILL;
                        start_q <= 1'b1;
                    end
                end
                dcache_pkg::REFILL:
                begin
                    // back to lookup, request now hits
                    if (move_done_i)
                    begin
                        state_q <= dcache_pkg::LOOKUP;
                    end
                end
                default:
                begin
                    state_q <= dcache_pkg::LOOKUP;
                end
            endcase
        end
    end

    // ack only inside an active bus cycle
    ack_in_cycle_a: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_o.ack |-> (cpu_req_i.cyc && cpu_req_i.stb));

    // one ack per request
    ack_single_a: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_o.ack |=> !cpu_rsp_o.ack);

    // refilled line must hit on the re-lookup, in the way the tracker chose
    refill_hits_a: assert property (@(posedge clk) disable iff (rst)
        (state_q == dcache_pkg::REFILL && move_done_i) |=> ##1
        (hit_i && hit_way_i == victim_way_i));

endmodule

//--- source/dcache_top.sv
`timescale 1ns/10ps

module dcache_top #(
    parameter int unsigned LINE_ADDR_LEN = 2,
    parameter int unsigned SET_ADDR_LEN  = 2,
    parameter int unsigned WAY_CNT       = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::wb_m2s_t cpu_req_i,
    output dcache_pkg::wb_s2m_t cpu_rsp_o,
    output dcache_pkg::wb_m2s_t mem_req_o,
    input  dcache_pkg::wb_s2m_t mem_rsp_i
);

    // tag is everything above set and word offset
    localparam int unsigned TAG_W = dcache_pkg::ADDR_W - SET_ADDR_LEN - LINE_ADDR_LEN
        - dcache_pkg::BYTE_OFF_W;
    localparam int unsigned WAY_W = $clog2(WAY_CNT);

    logic [SET_ADDR_LEN-1:0]       cpu_set;
    logic [TAG_W-1:0]              cpu_tag;
    logic [LINE_ADDR_LEN-1:0]      cpu_word;
    logic                          lookup;
    logic                          hit;
    logic [WAY_W-1:0]              hit_way;
    logic                          victim_dirty;
    logic [WAY_W-1:0]              victim_way;
    dcache_pkg::word_t             rd_word;
    logic                          wr_en;
    logic                          touch;
    logic                          move_start;
    logic                          move_write;
    logic                          move_done;
    logic [LINE_ADDR_LEN-1:0]      word_idx;
    logic                          fill_en;
    dcache_pkg::word_t             fill_data;
    dcache_pkg::word_t             evict_data;
    logic [TAG_W-1:0]              evict_tag;
    logic [TAG_W+SET_ADDR_LEN-1:0] line_adr;

    // split the cpu byte address
    assign cpu_word = cpu_req_i.adr[dcache_pkg::BYTE_OFF_W +: LINE_ADDR_LEN];
    assign cpu_set  = cpu_req_i.adr[dcache_pkg::BYTE_OFF_W + LINE_ADDR_LEN +: SET_ADDR_LEN];
    assign cpu_tag  = cpu_req_i.adr[dcache_pkg::ADDR_W-1 -: TAG_W];

    // write-back goes to the victim's old line, refill to the requested one
    assign line_adr = move_write ? {evict_tag, cpu_set} : {cpu_tag, cpu_set};

    dcache_ctrl #(
        .WAY_CNT (WAY_CNT)
    ) ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_i      (cpu_req_i),
        .cpu_rsp_o      (cpu_rsp_o),
        .lookup_o       (lookup),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .rd_word_i      (rd_word),
        .wr_en_o        (wr_en),
        .touch_o        (touch),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .move_start_o   (move_start),
        .move_write_o   (move_write),
        .move_done_i    (move_done)
    );

    dcache_store #(
        .LINE_ADDR_LEN (LINE_ADDR_LEN),
        .SET_ADDR_LEN  (SET_ADDR_LEN),
        .WAY_CNT       (WAY_CNT)
    ) store_inst (
        .clk            (clk),
        .rst            (rst),
        .set_i          (cpu_set),
        .tag_i          (cpu_tag),
        .word_i         (cpu_word),
        .lookup_i       (lookup),
        .wr_en_i        (wr_en),
        .wr_sel_i       (cpu_req_i.sel),
        .wr_data_i      (cpu_req_i.dat),
        .fill_en_i      (fill_en),
        .fill_way_i     (victim_way),
        .fill_word_i    (word_idx),
        .fill_data_i    (fill_data),
        .evict_way_i    (victim_way),
        .evict_word_i   (word_idx),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rd_word_o      (rd_word),
        .victim_dirty_o (victim_dirty),
        .evict_data_o   (evict_data),
        .evict_tag_o    (evict_tag)
    );

    lru_tracker #(
        .SET_ADDR_LEN (SET_ADDR_LEN),
        .WAY_CNT      (WAY_CNT)
    ) lru_inst (
        .clk          (clk),
        .rst          (rst),
        .set_i        (cpu_set),
        .touch_i      (touch),
        .touch_way_i  (hit_way),
        .victim_way_o (victim_way)
    );

    line_mover #(
        .LINE_ADDR_LEN (LINE_ADDR_LEN)
    ) mover_inst (
        .clk         (clk),
        .rst         (rst),
        .start_i     (move_start),
        .write_i     (move_write),
        .line_adr_i  (line_adr),
        .wr_word_i   (evict_data),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .word_idx_o  (word_idx),
        .fill_en_o   (fill_en),
        .fill_data_o (fill_data),
        .done_o      (move_done)
    );

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'he767_7527
) (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::wb_m2s_t req_i,
    output dcache_pkg::wb_s2m_t rsp_o
);

    // sparse backing store, untouched words read the fill pattern
    dcache_pkg::word_t mem_q [dcache_pkg::word_t];
    logic [31:0] lfsr_q;
    // wait cycles before the next ack
    logic [1:0]  delay_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // pattern mixes every address bit
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    always @(posedge clk)
    begin
        logic [31:0]       s1;
        logic [31:0]       s2;
        dcache_pkg::word_t cur;
        if (rst)
        begin
            rsp_o.ack <= 1'b0;
            rsp_o.dat <= '0;
            delay_q   <= 2'd0;
            lfsr_q    <= SEED;
        end
        else
        begin
            rsp_o.ack <= 1'b0;
            // one ack per beat, never on the cycle right after an ack
            if (req_i.cyc && req_i.stb && !rsp_o.ack)
            begin
                if (delay_q != 2'd0)
                    delay_q <= delay_q - 1'b1;
                else
                begin
                    cur = mem_q.exists(req_i.adr) ? mem_q[req_i.adr] : fill_word(req_i.adr);
                    if (req_i.we)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (req_i.sel[b])
                                cur[b*8 +: 8] = req_i.dat[b*8 +: 8];
                        mem_q[req_i.adr] = cur;
                    end
                    rsp_o.ack <= 1'b1;
                    rsp_o.dat <= cur;
                    // two bits for the next delay
                    s1 = lfsr_next(lfsr_q);
                    s2 = lfsr_next(s1);
                    delay_q <= {s1[0], s2[0]};
                    lfsr_q  <= s2;
                end
            end
        end
    end

endmodule

//--- tb/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache;

    localparam int PERIOD      = 40;
    localparam int RST_CYCLES  = 16;
    localparam int N_RAND      = 320;
    localparam int N_REQ       = N_RAND + 9;
    // two bursts at the longest ack delay plus lookups
    localparam int MISS_CYCLES = 64;
    localparam int WATCHDOG_NS = (RST_CYCLES + 8 + N_REQ * MISS_CYCLES) * PERIOD;
    localparam int SETS        = 4;
    localparam int WAYS        = 4;
    // upper tag bits fixed, three tag bits vary so sets overflow
    localparam logic [22:0] TAG_HI = 23'h5c_3a6b;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    dcache_pkg::wb_m2s_t cpu_req;
    dcache_pkg::wb_s2m_t cpu_rsp;
    dcache_pkg::wb_m2s_t mem_req;
    dcache_pkg::wb_s2m_t mem_rsp;

    logic [31:0]       lfsr = 32'he767_7527;
    // word index is {tag3, set, word}
    dcache_pkg::word_t shadow [128];

    // reference cache state
    logic [2:0] m_tag   [SETS][WAYS];
    logic       m_valid [SETS][WAYS];
    logic       m_dirty [SETS][WAYS];
    int         m_age   [SETS][WAYS];

    // what the current request should do
    logic              exp_hit        = 1'b0;
    logic              exp_evict      = 1'b0;
    logic [27:0]       exp_evict_line = '0;
    logic [27:0]       exp_line       = '0;
    dcache_pkg::word_t exp_dat        = '0;
    int                wb_base        = 0;
    int                rf_base        = 0;

    // bus monitor state
    logic seen_req;
    logic mem_cyc_q;
    logic mem_we_q;
    int   wait_cnt;
    int   beat_cnt;
    int   wb_bursts;
    int   rf_bursts;

    int mismatch_errs = 0;
    int protocol_errs = 0;

    dcache_pkg::sel_t dir_sel [4]     = '{4'hf, 4'h3, 4'h4, 4'hc};
    int               touch_order [4] = '{2, 0, 3, 1};

    always #(PERIOD / 2) clk = ~clk;

    dcache_top #(
        .LINE_ADDR_LEN (2),
        .SET_ADDR_LEN  (2),
        .WAY_CNT       (WAYS)
    ) dcache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    tb_mem_model mem_model_inst (
        .clk   (clk),
        .rst   (rst),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // same pattern the memory model starts from
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // youngest gets 0, the rest age up to 255
    task automatic age_touch(input logic [1:0] s, input int w);
        for (int i = 0; i < WAYS; i++)
            if (i == w)
                m_age[s][i] = 0;
            else if (m_age[s][i] < 255)
                m_age[s][i] = m_age[s][i] + 1;
    endtask

    task automatic predict_access(input logic [6:0] idx, input logic we);
        logic [1:0] s;
        logic [2:0] t;
        int         hw;
        int         vw;
        s  = idx[3:2];
        t  = idx[6:4];
        hw = -1;
        for (int w = 0; w < WAYS; w++)
            if (m_valid[s][w] && m_tag[s][w] == t)
                hw = w;
        exp_hit   = (hw >= 0);
        exp_evict = 1'b0;
        if (hw < 0)
        begin
            // oldest way, lowest index on ties
            vw = 0;
            for (int w = 1; w < WAYS; w++)
                if (m_age[s][w] > m_age[s][vw])
                    vw = w;
            exp_evict      = m_valid[s][vw] && m_dirty[s][vw];
            exp_evict_line = {TAG_HI, m_tag[s][vw], s};
            m_tag[s][vw]   = t;
            m_valid[s][vw] = 1'b1;
            m_dirty[s][vw] = 1'b0;
            hw = vw;
        end
        if (we)
            m_dirty[s][hw] = 1'b1;
        age_touch(s, hw);
    endtask

    task automatic run_access(input logic [6:0] idx, input logic we,
                              input dcache_pkg::sel_t sel, input dcache_pkg::word_t dat);
        logic [31:0] gap;
        @(negedge clk);
        predict_access(idx, we);
        exp_line    = {TAG_HI, idx[6:2]};
        exp_dat     = shadow[idx];
        wb_base     = wb_bursts;
        rf_base     = rf_bursts;
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we  = we;
        cpu_req.sel = sel;
        cpu_req.adr = {TAG_HI, idx, 2'b00};
        cpu_req.dat = dat;
        // ack seen mid cycle is taken at the next rising edge
        do
            @(negedge clk);
        while (!cpu_rsp.ack);
        @(posedge clk);
        if (we)
            for (int b = 0; b < 4; b++)
                if (sel[b])
                    shadow[idx][b*8 +: 8] = dat[b*8 +: 8];
        // sometimes an idle cycle between requests
        draw_bits(1, gap);
        if (gap[0])
        begin
            @(negedge clk);
            cpu_req.cyc = 1'b0;
            cpu_req.stb = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            seen_req  <= 1'b0;
            mem_cyc_q <= 1'b0;
            mem_we_q  <= 1'b0;
            wait_cnt  <= 0;
            beat_cnt  <= 0;
            wb_bursts <= 0;
            rf_bursts <= 0;
        end
        else
        begin
            if (cpu_req.cyc && cpu_req.stb)
                seen_req <= 1'b1;
            // cycles since the request was first sampled
            if (cpu_rsp.ack)
                wait_cnt <= 0;
            else if (cpu_req.cyc && cpu_req.stb)
                wait_cnt <= wait_cnt + 1;
            mem_cyc_q <= mem_req.cyc;
            mem_we_q  <= mem_req.we;
            if (!mem_req.cyc)
                beat_cnt <= 0;
            else if (mem_rsp.ack)
                beat_cnt <= beat_cnt + 1;
            // count finished bursts by direction
            if (mem_cyc_q && !mem_req.cyc)
            begin
                if (mem_we_q)
                    wb_bursts <= wb_bursts + 1;
                else
                    rf_bursts <= rf_bursts + 1;
            end
        end
    end

    idle_after_reset_a: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> (!cpu_rsp.ack && !mem_req.cyc && !mem_req.stb))
    else
    begin
        protocol_errs++;
        $display("%0t: cache raised ack, mem cyc or mem stb before any request", $time);
    end

    read_data_a: assert property (@(posedge clk) disable iff (rst)
        (cpu_rsp.ack && !cpu_req.we) |-> (cpu_rsp.dat == exp_dat))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: read data %h, expected %h", $time, cpu_rsp.dat, exp_dat);
    end

    hit_no_mem_a: assert property (@(posedge clk) disable iff (rst)
        (exp_hit && cpu_req.cyc && cpu_req.stb) |-> !mem_req.cyc)
    else
    begin
        protocol_errs++;
        $display("%0t: memory cycle started on a request that should hit", $time);
    end

    hit_latency_a: assert property (@(posedge clk) disable iff (rst)
        (cpu_rsp.ack && exp_hit) |-> (wait_cnt == 2))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: hit acked after %0d cycles, expected 2", $time, wait_cnt);
    end

    wb_data_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.cyc && mem_req.we && mem_rsp.ack) |-> (mem_req.dat == shadow[mem_req.adr[8:2]]))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: write-back word %h at %h, expected %h", $time,
                 mem_req.dat, mem_req.adr, shadow[mem_req.adr[8:2]]);
    end

    // victim line from the reference lru
    wb_line_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.cyc && mem_req.we) |-> (mem_req.adr[31:4] == exp_evict_line))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: write-back line %h, expected %h", $time,
                 mem_req.adr[31:4], exp_evict_line);
    end

    refill_line_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.cyc && !mem_req.we) |-> (mem_req.adr[31:4] == exp_line))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: refill line %h, expected %h", $time,
                 mem_req.adr[31:4], exp_line);
    end

    // write-back finished before the refill, one refill per miss
    refill_order_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.cyc && !mem_req.we) |->
        ((wb_bursts - wb_base) == (exp_evict ? 1 : 0) && rf_bursts == rf_base))
    else
    begin
        protocol_errs++;
        $display("%0t: refill started out of order with the write-back", $time);
    end

    beat_addr_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.cyc && mem_rsp.ack) |->
        (mem_req.adr[3:2] == beat_cnt[1:0] && mem_req.adr[1:0] == 2'b00 && beat_cnt < 4))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: beat address %h at beat %0d", $time, mem_req.adr, beat_cnt);
    end

    burst_len_a: assert property (@(posedge clk) disable iff (rst)
        (mem_cyc_q && !mem_req.cyc) |-> (beat_cnt == 4))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: burst of %0d beats, expected 4", $time, beat_cnt);
    end

    // stb follows cyc and every beat moves all four lanes
    mem_strobe_a: assert property (@(posedge clk) disable iff (rst)
        (mem_req.stb == mem_req.cyc) && (!mem_req.cyc || mem_req.sel == 4'hf))
    else
    begin
        mismatch_errs++;
        $display("MISMATCH %0t: mem stb %b cyc %b sel %h, expected stb equal to cyc and sel f",
                 $time, mem_req.stb, mem_req.cyc, mem_req.sel);
    end

    miss_traffic_a: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.ack |-> ((rf_bursts - rf_base) == (exp_hit ? 0 : 1)
                         && (wb_bursts - wb_base) == (exp_evict ? 1 : 0)))
    else
    begin
        protocol_errs++;
        $display("%0t: memory bursts for this request differ from hit and miss rules", $time);
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run exceeded %0d ns without finishing", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial
    begin
        logic [31:0]      r;
        logic [6:0]       idx;
        logic             we;
        dcache_pkg::sel_t sel;
        cpu_req = '0;
        for (int i = 0; i < 128; i++)
            shadow[i] = fill_word({TAG_HI, 7'(i), 2'b00});
        for (int s = 0; s < SETS; s++)
            for (int w = 0; w < WAYS; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = 3'd0;
                m_age[s][w]   = 255;
            end
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        // quiet bus after reset
        repeat (4) @(negedge clk);
        // fill set 1 with four dirty lines, masks of several widths
        for (int t = 0; t < 4; t++)
        begin
            draw_bits(32, r);
            run_access({3'(t), 2'd1, 2'(t)}, 1'b1, dir_sel[t], r);
        end
        // touch order leaves tag 2 oldest
        for (int i = 0; i < 4; i++)
            run_access({3'(touch_order[i]), 2'd1, 2'(touch_order[i])}, 1'b0, 4'hf, 32'h0);
        // new tag evicts the predicted line
        run_access({3'd5, 2'd1, 2'd3}, 1'b0, 4'hf, 32'h0);
        for (int n = 0; n < N_RAND; n++)
        begin
            draw_bits(7, r);
            idx = r[6:0];
            draw_bits(1, r);
            we = r[0];
            draw_bits(4, r);
            sel = (r[3:0] == 4'h0) ? 4'hf : r[3:0];
            draw_bits(32, r);
            run_access(idx, we, sel, r);
        end
        @(negedge clk);
        cpu_req = '0;
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d protocol failures, %0d requests",
                 mismatch_errs, protocol_errs, N_REQ);
        if (mismatch_errs == 0 && protocol_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- files.f
source/dcache_pkg.sv
source/lru_tracker.sv
source/dcache_store.sv
source/line_mover.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module tb_dcache -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^test passed$"; then
    exit 0
fi
exit 1
